//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_tuple_merger
RTL_TOP   ?= tuple_merger
FILELIST  ?= tuple_merger.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
LINTFLAGS ?= --lint-only -Wall --timescale 1ns/1ps

RTL_SRCS := $(filter rtl/%,$(shell cat $(FILELIST)))
SIM      := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

lint:
	$(VERILATOR) $(LINTFLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- rtl/bitonic_merge_net.sv
`timescale 1ns/1ps

module bitonic_merge_net #(
   parameter int KEY_W = 32,
   parameter int KEYS  = 4
) (
   input  logic                   i_clk,
   input  logic                   i_rst_n,
   input  logic                   i_issue,
   input  merge_pkg::net_op_e     i_op,
   input  logic                   i_sel_b,
   input  logic [KEYS*KEY_W-1:0]  i_a_tuple,
   input  logic [KEYS*KEY_W-1:0]  i_b_tuple,
   output logic                   o_busy,
   output logic                   o_emit,
   output logic [KEYS*KEY_W-1:0]  o_tuple
);

   localparam int LOG     = $clog2(2 * KEYS);
   localparam int NET_LAT = LOG + 1; // input register plus one per half-cleaner.

   typedef logic [KEYS-1:0][KEY_W-1:0]   tuple_t;
   typedef logic [2*KEYS-1:0][KEY_W-1:0] seq_t;

   tuple_t             new_q;
   tuple_t             held_q;
   logic               held_vld_q;
   merge_pkg::net_op_e op_q [NET_LAT];
   logic [NET_LAT-1:0] vld_q;
   seq_t               seq_first;
   seq_t               seq_out [LOG];
   seq_t               seq_q [LOG];
   merge_pkg::net_op_e wb_op;
   seq_t               wb_seq;

   function automatic logic is_ascending(input tuple_t t);
      logic ok;
      ok = 1'b1;
      for (int i = 1; i < KEYS; i++) begin
         if (t[i] < t[i-1]) begin
            ok = 1'b0;
         end
      end
      return ok;
   endfunction

   // held tuple in the low slots, new tuple reversed above it.
   always_comb begin
      seq_first = {(2 * KEYS){KEY_W'(merge_pkg::END_KEY)}};
      case (op_q[0])
         merge_pkg::OP_MERGE: begin
            for (int i = 0; i < KEYS; i++) begin
               seq_first[i]        = held_q[i];
               seq_first[KEYS + i] = new_q[KEYS - 1 - i];
            end
         end
         merge_pkg::OP_LOAD:  seq_first[KEYS-1:0] = new_q;
         merge_pkg::OP_FLUSH: seq_first[KEYS-1:0] = held_q;
         default: ;
      endcase
   end

   for (genvar j = 0; j < LOG; j++) begin : g_stage
      localparam int D = KEYS >> j;
      seq_t stage_in;
      if (j == 0) begin : g_head
         assign stage_in = seq_first;
      end else begin : g_tail
         assign stage_in = seq_q[j-1];
      end
      for (genvar i = 0; i < 2 * KEYS; i++) begin : g_pair
         if ((i % (2 * D)) < D) begin : g_cmp
            logic swap;
            // only merges compare; other ops pass straight through.
            assign swap = (op_q[j] == merge_pkg::OP_MERGE) && (stage_in[i] > stage_in[i + D]);
            assign seq_out[j][i]     = swap ? stage_in[i + D] : stage_in[i];
            assign seq_out[j][i + D] = swap ? stage_in[i] : stage_in[i + D];
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_issue) begin
         new_q   <= i_sel_b ? i_b_tuple : i_a_tuple;
         op_q[0] <= i_op;
      end
      for (int j = 0; j < LOG; j++) begin
         seq_q[j] <= seq_out[j];
      end
      for (int k = 1; k < NET_LAT; k++) begin
         op_q[k] <= op_q[k-1];
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         vld_q <= '0;
      end else begin
         vld_q <= {vld_q[NET_LAT-2:0], i_issue};
      end
   end

   // upper half goes back as the final stage is loaded.
   assign wb_op  = op_q[NET_LAT-2];
   assign wb_seq = seq_out[LOG-1];

   always_ff @(posedge i_clk) begin
      if (vld_q[NET_LAT-2]) begin
         if (wb_op == merge_pkg::OP_MERGE) begin
            held_q <= wb_seq[2*KEYS-1:KEYS];
         end else if (wb_op == merge_pkg::OP_LOAD) begin
            held_q <= wb_seq[KEYS-1:0];
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         held_vld_q <= 1'b0;
      end else if (vld_q[NET_LAT-2]) begin
         case (wb_op)
            merge_pkg::OP_LOAD,
            merge_pkg::OP_MERGE: held_vld_q <= 1'b1;
            merge_pkg::OP_FLUSH: held_vld_q <= 1'b0;
            default: ;
         endcase
      end
   end

   assign o_busy  = |vld_q[NET_LAT-2:0];
   assign o_emit  = vld_q[NET_LAT-1] && (op_q[NET_LAT-1] != merge_pkg::OP_LOAD);
   assign o_tuple = seq_q[LOG-1][KEYS-1:0];

   a_emit_sorted: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_emit |-> is_ascending(o_tuple));

   // the controller only merges or flushes after a load in the same run.
   a_held_ready: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (i_issue && (i_op == merge_pkg::OP_MERGE || i_op == merge_pkg::OP_FLUSH))
      |-> held_vld_q);

endmodule

//--- rtl/merge_control.sv
`timescale 1ns/1ps

module merge_control #(
   parameter int KEY_W  = 32,
   parameter int FREE_W = 5
) (
   input  logic               i_clk,
   input  logic               i_rst_n,
   input  logic [KEY_W-1:0]   i_a_key,
   input  logic [KEY_W-1:0]   i_b_key,
   input  logic               i_a_empty,
   input  logic               i_b_empty,
   input  logic               i_busy,
   input  logic [FREE_W-1:0]  i_out_free,
   output logic               o_pop_a,
   output logic               o_pop_b,
   output logic               o_issue,
   output merge_pkg::net_op_e o_op,
   output logic               o_sel_b
);

   merge_pkg::merge_state_e state_q;
   merge_pkg::merge_state_e state_d;
   logic                    loaded_q;
   logic                    loaded_d;
   logic                    a_mark;
   logic                    b_mark;
   logic                    can_issue;
   merge_pkg::net_op_e      pop_op;

   assign a_mark = (i_a_key == KEY_W'(merge_pkg::END_KEY));
   assign b_mark = (i_b_key == KEY_W'(merge_pkg::END_KEY));

   // one slot for a result still in the network, one for this one.
   assign can_issue = !i_busy && (i_out_free >= FREE_W'(2));
   assign pop_op    = loaded_q ? merge_pkg::OP_MERGE : merge_pkg::OP_LOAD;

   always_comb begin
      state_d  = state_q;
      loaded_d = loaded_q;
      o_pop_a  = 1'b0;
      o_pop_b  = 1'b0;
      o_issue  = 1'b0;
      o_op     = merge_pkg::OP_LOAD;
      o_sel_b  = 1'b0;
      case (state_q)
         merge_pkg::ST_MERGE: begin
            if (!i_a_empty && !i_b_empty) begin
               if (a_mark && b_mark) begin
                  o_pop_a = 1'b1;
                  o_pop_b = 1'b1;
                  state_d = merge_pkg::ST_FLUSH;
               end else if (a_mark) begin
                  o_pop_a = 1'b1; // drop A's marker, finish from B.
                  state_d = merge_pkg::ST_DRAIN_B;
               end else if (b_mark) begin
                  o_pop_b = 1'b1;
                  state_d = merge_pkg::ST_DRAIN_A;
               end else if (can_issue) begin
                  o_sel_b  = (i_b_key < i_a_key); // ties go to A.
                  o_pop_a  = !o_sel_b;
                  o_pop_b  = o_sel_b;
                  o_issue  = 1'b1;
                  o_op     = pop_op;
                  loaded_d = 1'b1;
               end
            end
         end
         merge_pkg::ST_DRAIN_A: begin
            if (!i_a_empty) begin
               if (a_mark) begin
                  o_pop_a = 1'b1;
                  state_d = merge_pkg::ST_FLUSH;
               end else if (can_issue) begin
                  o_pop_a  = 1'b1;
                  o_issue  = 1'b1;
                  o_op     = pop_op;
                  loaded_d = 1'b1;
               end
            end
         end
         merge_pkg::ST_DRAIN_B: begin
            o_sel_b = 1'b1;
            if (!i_b_empty) begin
               if (b_mark) begin
                  o_pop_b = 1'b1;
                  state_d = merge_pkg::ST_FLUSH;
               end else if (can_issue) begin
                  o_pop_b  = 1'b1;
                  o_issue  = 1'b1;
                  o_op     = pop_op;
                  loaded_d = 1'b1;
               end
            end
         end
         merge_pkg::ST_FLUSH: begin
            if (!loaded_q) begin
               state_d = merge_pkg::ST_MARK; // empty run, nothing held.
            end else if (can_issue) begin
               o_issue  = 1'b1;
               o_op     = merge_pkg::OP_FLUSH;
               loaded_d = 1'b0;
               state_d  = merge_pkg::ST_MARK;
            end
         end
         merge_pkg::ST_MARK: begin
            if (can_issue) begin
               o_issue = 1'b1;
               o_op    = merge_pkg::OP_MARK;
               state_d = merge_pkg::ST_WAIT;
            end
         end
         merge_pkg::ST_WAIT: begin
            // let the marker leave the network before the next run starts.
            if (!i_busy) begin
               state_d = merge_pkg::ST_MERGE;
            end
         end
         default: state_d = merge_pkg::ST_MERGE;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         state_q  <= merge_pkg::ST_MERGE;
         loaded_q <= 1'b0;
      end else begin
         state_q  <= state_d;
         loaded_q <= loaded_d;
      end
   end

   // the network takes every issue and goes busy on the next cycle.
   a_issue_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_issue |-> !i_busy ##1 i_busy);

endmodule

//--- rtl/merge_pkg.sv
package merge_pkg;

   // merge controller states.
   typedef enum logic [2:0] {
      ST_MERGE,
      ST_DRAIN_A,
      ST_DRAIN_B,
      ST_FLUSH,
      ST_MARK,
      ST_WAIT
   } merge_state_e;

   // network opcodes.
   typedef enum logic [1:0] {
      OP_LOAD,   // new tuple becomes the held tuple.
      OP_MERGE,  // emit lower half, keep upper half.
      OP_FLUSH,  // emit the held tuple.
      OP_MARK    // emit an all-zero marker.
   } net_op_e;

   // a tuple whose lowest key is this value ends a run.
   localparam int unsigned END_KEY = 0;

endpackage

//--- rtl/tuple_fifo.sv
`timescale 1ns/1ps

module tuple_fifo #(
   parameter int WIDTH = 128,
   parameter int DEPTH = 16
) (
   input  logic                   i_clk,
   input  logic                   i_rst_n,
   input  logic                   i_push,
   input  logic [WIDTH-1:0]       i_data,
   input  logic                   i_pop,
   output logic [WIDTH-1:0]       o_data,
   output logic                   o_empty,
   output logic                   o_full,
   output logic [$clog2(DEPTH):0] o_free
);

   localparam int AW = $clog2(DEPTH);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [AW-1:0]    wr_ptr_q;
   logic [AW-1:0]    rd_ptr_q;
   logic [AW:0]      count_q;
   logic             push_ok;
   logic             pop_ok;

   assign push_ok = i_push && !o_full;
   assign pop_ok  = i_pop && !o_empty;

   assign o_data  = mem[rd_ptr_q]; // first word falls through.
   assign o_empty = (count_q == '0);
   assign o_full  = (count_q == (AW+1)'(DEPTH));
   assign o_free  = (AW+1)'(DEPTH) - count_q;

   always_ff @(posedge i_clk) begin
      if (push_ok) begin
         mem[wr_ptr_q] <= i_data;
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push_ok) begin
            wr_ptr_q <= wr_ptr_q + 1'b1; // depth is a power of two, so it wraps.
         end
         if (pop_ok) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({push_ok, pop_ok})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // the producer must respect full.
   a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_push |-> !o_full);

   // the consumer must respect empty.
   a_no_underflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_pop |-> !o_empty);

endmodule

//--- rtl/tuple_merger.sv
`timescale 1ns/1ps

module tuple_merger #(
   parameter int KEY_W      = 32,
   parameter int KEYS       = 4,
   parameter int FIFO_DEPTH = 16
) (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  logic [KEYS*KEY_W-1:0] i_a_data,
   input  logic                  i_a_valid,
   output logic                  o_a_read,
   input  logic [KEYS*KEY_W-1:0] i_b_data,
   input  logic                  i_b_valid,
   output logic                  o_b_read,
   output logic [KEYS*KEY_W-1:0] o_out_data,
   output logic                  o_out_valid,
   input  logic                  i_out_ready,
   output logic                  o_out_read_pop
);

   localparam int TW     = KEYS * KEY_W;
   localparam int FREE_W = $clog2(FIFO_DEPTH) + 1;

   logic               a_full;
   logic               b_full;
   logic               a_empty;
   logic               b_empty;
   logic [TW-1:0]      a_head;
   logic [TW-1:0]      b_head;
   logic               pop_a;
   logic               pop_b;
   logic               issue;
   merge_pkg::net_op_e op;
   logic               sel_b;
   logic               busy;
   logic               emit;
   logic [TW-1:0]      emit_tuple;
   logic               out_empty;
   logic [FREE_W-1:0]  out_free;
   logic               ready_q;

   assign o_a_read       = i_a_valid && !a_full;
   assign o_b_read       = i_b_valid && !b_full;
   assign o_out_valid    = !out_empty;
   assign o_out_read_pop = ready_q && !out_empty;

   // ready is sampled one cycle late.
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         ready_q <= 1'b0;
      end else begin
         ready_q <= i_out_ready;
      end
   end

   tuple_fifo #(.WIDTH(TW), .DEPTH(FIFO_DEPTH)) fifo_a (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_push  (o_a_read),
      .i_data  (i_a_data),
      .i_pop   (pop_a),
      .o_data  (a_head),
      .o_empty (a_empty),
      .o_full  (a_full),
      .o_free  ()
   );

   tuple_fifo #(.WIDTH(TW), .DEPTH(FIFO_DEPTH)) fifo_b (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_push  (o_b_read),
      .i_data  (i_b_data),
      .i_pop   (pop_b),
      .o_data  (b_head),
      .o_empty (b_empty),
      .o_full  (b_full),
      .o_free  ()
   );

   merge_control #(.KEY_W(KEY_W), .FREE_W(FREE_W)) u_control (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_a_key    (a_head[KEY_W-1:0]), // lowest key sits in slot 0.
      .i_b_key    (b_head[KEY_W-1:0]),
      .i_a_empty  (a_empty),
      .i_b_empty  (b_empty),
      .i_busy     (busy),
      .i_out_free (out_free),
      .o_pop_a    (pop_a),
      .o_pop_b    (pop_b),
      .o_issue    (issue),
      .o_op       (op),
      .o_sel_b    (sel_b)
   );

   bitonic_merge_net #(.KEY_W(KEY_W), .KEYS(KEYS)) u_net (
      .i_clk     (i_clk),
      .i_rst_n   (i_rst_n),
      .i_issue   (issue),
      .i_op      (op),
      .i_sel_b   (sel_b),
      .i_a_tuple (a_head),
      .i_b_tuple (b_head),
      .o_busy    (busy),
      .o_emit    (emit),
      .o_tuple   (emit_tuple)
   );

   tuple_fifo #(.WIDTH(TW), .DEPTH(FIFO_DEPTH)) fifo_out (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_push  (emit),
      .i_data  (emit_tuple),
      .i_pop   (o_out_read_pop),
      .o_data  (o_out_data),
      .o_empty (out_empty),
      .o_full  (),
      .o_free  (out_free)
   );

endmodule

//--- tuple_merger.f
rtl/merge_pkg.sv
rtl/tuple_fifo.sv
rtl/merge_control.sv
rtl/bitonic_merge_net.sv
rtl/tuple_merger.sv
verif/tb_tuple_merger.sv

//--- verif/merge_patterns.hex
// tag, then keys 3 down to 0; key 0 sits in the lowest slot.
// tag 0 = input A, 1 = input B, 2 = expected output; zero keys mark a run end.
// run 1, equal lengths with interleaved keys.
0_00000007_00000005_00000003_00000001
0_0000000f_0000000d_0000000b_00000009
0_00000000_00000000_00000000_00000000
1_00000008_00000006_00000004_00000002
1_00000010_0000000e_0000000c_0000000a
1_00000000_00000000_00000000_00000000
2_00000004_00000003_00000002_00000001
2_00000008_00000007_00000006_00000005
2_0000000c_0000000b_0000000a_00000009
2_00000010_0000000f_0000000e_0000000d
2_00000000_00000000_00000000_00000000
// run 2, A much longer, so A is drained.
0_00000023_00000022_00000021_00000020
0_00000027_00000026_00000025_00000024
0_0000002b_0000002a_00000029_00000028
0_0000002f_0000002e_0000002d_0000002c
0_00000033_00000032_00000031_00000030
0_00000000_00000000_00000000_00000000
1_00000035_00000034_0000002a_00000025
1_00000000_00000000_00000000_00000000
2_00000023_00000022_00000021_00000020
2_00000026_00000025_00000025_00000024
2_0000002a_00000029_00000028_00000027
2_0000002d_0000002c_0000002b_0000002a
2_00000031_00000030_0000002f_0000002e
2_00000035_00000034_00000033_00000032
2_00000000_00000000_00000000_00000000
// run 3, duplicate keys on both sides.
0_00000006_00000006_00000005_00000005
0_00000009_00000008_00000008_00000007
0_00000000_00000000_00000000_00000000
1_00000007_00000006_00000006_00000005
1_00000009_00000009_00000009_00000008
1_00000000_00000000_00000000_00000000
2_00000006_00000005_00000005_00000005
2_00000007_00000006_00000006_00000006
2_00000008_00000008_00000008_00000007
2_00000009_00000009_00000009_00000009
2_00000000_00000000_00000000_00000000
// run 4, B longer, so B is drained.
0_00000100_000000c0_00000080_00000040
0_00000000_00000000_00000000_00000000
1_00000050_00000030_00000020_00000010
1_000000a0_00000090_00000070_00000060
1_000000f0_000000e0_000000d0_000000b0
1_00000000_00000000_00000000_00000000
2_00000040_00000030_00000020_00000010
2_00000080_00000070_00000060_00000050
2_000000c0_000000b0_000000a0_00000090
2_00000100_000000f0_000000e0_000000d0
2_00000000_00000000_00000000_00000000

//--- verif/tb_tuple_merger.sv
`timescale 1ns/1ps

module tb_tuple_merger;

   localparam int KEY_W      = 32;
   localparam int KEYS       = 4;
   localparam int FIFO_DEPTH = 16;
   localparam int TW         = KEYS * KEY_W;
   localparam int PW         = TW + 4; // tag nibble above the tuple.
   localparam int PAT_DEPTH  = 128;
   localparam int STIM_MAX   = 64;
   localparam int HOLD_CYC   = 150; // long enough for the output FIFO to fill up.

   logic             i_clk;
   logic             i_rst_n;
   logic [TW-1:0]    in_data [2];
   logic [1:0]       in_valid;
   logic [1:0]       in_read;
   logic [TW-1:0]    o_out_data;
   logic             o_out_valid;
   logic             i_out_ready;
   logic             o_out_read_pop;

   logic [PW-1:0]    pat_mem [PAT_DEPTH];
   logic [TW-1:0]    stim_mem [2][STIM_MAX];
   logic [TW-1:0]    exp_mem [STIM_MAX];
   int               n_stim [2];
   int               n_exp;
   int               n_lines;
   int               n_got;
   int               errors;
   logic [1:0]       feed_done;
   logic             started;
   logic             loaded;
   logic             in_run;
   logic [KEY_W-1:0] prev_high;
   logic             ready_seen;
   integer           seed = 58;

   tuple_merger #(
      .KEY_W      (KEY_W),
      .KEYS       (KEYS),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) DUT (
      .i_clk          (i_clk),
      .i_rst_n        (i_rst_n),
      .i_a_data       (in_data[0]),
      .i_a_valid      (in_valid[0]),
      .o_a_read       (in_read[0]),
      .i_b_data       (in_data[1]),
      .i_b_valid      (in_valid[1]),
      .o_b_read       (in_read[1]),
      .o_out_data     (o_out_data),
      .o_out_valid    (o_out_valid),
      .i_out_ready    (i_out_ready),
      .o_out_read_pop (o_out_read_pop)
   );

   always #5 i_clk = ~i_clk;

   task automatic load_patterns();
      logic [3:0]    tag;
      logic [TW-1:0] tuple;
      for (int i = 0; i < PAT_DEPTH; i++) begin
         pat_mem[i] = {4'hF, TW'(i)}; // lines past the file end keep tag F.
      end
      $readmemh("verif/merge_patterns.hex", pat_mem);
      for (int i = 0; i < PAT_DEPTH; i++) begin
         tag   = pat_mem[i][PW-1 -: 4];
         tuple = pat_mem[i][TW-1:0];
         if (tag != 4'hF) begin
            n_lines++;
         end
         case (tag)
            4'h0, 4'h1: begin
               stim_mem[tag[0]][n_stim[tag[0]]] = tuple;
               n_stim[tag[0]]++;
            end
            4'h2: begin
               exp_mem[n_exp] = tuple;
               n_exp++;
            end
            4'hF: ;
            default: begin
               errors++;
               $display("pattern line %0d has an unknown tag %h", i, tag);
            end
         endcase
      end
   endtask

   // one input side, random idle gaps, each tuple held until it is read.
   task automatic feed_side(input int side);
      int gap;
      for (int i = 0; i < n_stim[side]; i++) begin
         gap = int'($unsigned($random(seed)) % 4);
         repeat (gap) begin
            @(posedge i_clk);
            #1;
         end
         in_data[side]  = stim_mem[side][i];
         in_valid[side] = 1'b1;
         do begin
            @(negedge i_clk);
         end while (!in_read[side]);
         @(posedge i_clk);
         #1;
         in_valid[side] = 1'b0;
      end
      feed_done[side] = 1'b1;
   endtask

   task automatic check_output(input logic [TW-1:0] got);
      logic [KEY_W-1:0] low;
      low = got[KEY_W-1:0];
      if (n_got < n_exp) begin
         assert (got === exp_mem[n_got]) else begin
            errors++;
            $display("FAIL t=%0t o_out_data tuple %0d expected %h got %h",
                     $time, n_got, exp_mem[n_got], got);
         end
      end
      if (low != '0) begin
         for (int k = 1; k < KEYS; k++) begin
            assert (got[k*KEY_W +: KEY_W] >= got[(k-1)*KEY_W +: KEY_W]) else begin
               errors++;
               $display("FAIL t=%0t o_out_data slot %0d expected >= %h got %h", $time, k,
                        got[(k-1)*KEY_W +: KEY_W], got[k*KEY_W +: KEY_W]);
            end
         end
         assert (!in_run || low >= prev_high) else begin
            errors++;
            $display("FAIL t=%0t o_out_data lowest key expected >= %h got %h",
                     $time, prev_high, low);
         end
         in_run    = 1'b1;
         prev_high = got[TW-1 -: KEY_W];
      end else begin
         in_run = 1'b0; // a marker closes the run.
      end
      n_got++;
   endtask

   initial begin
      wait (started);
      feed_side(0);
   end

   initial begin
      wait (started);
      feed_side(1);
   end

   // random back-pressure on the output, after a long stall at the start.
   initial begin
      wait (started);
      repeat (HOLD_CYC) begin
         @(posedge i_clk);
      end
      forever begin
         @(posedge i_clk);
         #1;
         i_out_ready = ($unsigned($random(seed)) % 4) != 0;
      end
   end

   always @(posedge i_clk) begin
      ready_seen <= i_out_ready; // ready as the DUT sees it, one cycle late.
   end

   // the tuple is consumed at the next rising edge.
   always @(negedge i_clk) begin
      if (i_rst_n) begin
         assert (o_out_read_pop === (ready_seen && o_out_valid)) else begin
            errors++;
            $display("FAIL t=%0t o_out_read_pop expected %b got %b",
                     $time, ready_seen && o_out_valid, o_out_read_pop);
         end
         if (o_out_read_pop) begin
            check_output(o_out_data);
         end
      end
   end

   initial begin
      int limit;
      wait (loaded);
      limit = 40 * n_lines + 200;
      repeat (limit) @(posedge i_clk);
      errors++;
      $display("timeout after %0d cycles with %0d of %0d output tuples seen",
               limit, n_got, n_exp);
      $display("errors %0d, output tuples %0d of %0d", errors, n_got, n_exp);
      $display("STATUS: FAIL");
      $finish;
   end

   initial begin
      i_clk       = 1'b0;
      i_rst_n     = 1'b0;
      in_data[0]  = '0;
      in_data[1]  = '0;
      in_valid    = '0;
      i_out_ready = 1'b0;
      ready_seen  = 1'b0;
      feed_done   = '0;
      started     = 1'b0;
      loaded      = 1'b0;
      in_run      = 1'b0;
      prev_high   = '0;
      n_stim[0]   = 0;
      n_stim[1]   = 0;
      n_exp       = 0;
      n_lines     = 0;
      n_got       = 0;
      errors      = 0;
      load_patterns();
      loaded = 1'b1;
      repeat (2) @(posedge i_clk);
      #1;
      i_rst_n = 1'b1;
      started = 1'b1;
      wait (n_got >= n_exp && feed_done == 2'b11);
      repeat (40) @(posedge i_clk); // room for a stray extra tuple.
      assert (n_got == n_exp) else begin
         errors++;
         $display("FAIL t=%0t output tuple count expected %0d got %0d", $time, n_exp, n_got);
      end
      assert (!o_out_valid) else begin
         errors++;
         $display("FAIL t=%0t o_out_valid expected 0 got %b", $time, o_out_valid);
      end
      $display("errors %0d, output tuples %0d of %0d", errors, n_got, n_exp);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule
